// ==== include/sc_macros.svh ====
`ifndef SC_MACROS_SVH
`define SC_MACROS_SVH

// parameter word width
`define SC_WORD_W 16

// parameter fifo geometry
`define SC_FIFO_DEPTH 16
`define SC_FIFO_AW 4

// sr_rstb low time in Clk_5M cycles
`define SC_RSTB_CYCLES 4

// apb register offsets
`define SC_REG_CTRL 4'h0
`define SC_REG_DATA 4'h4
`define SC_REG_STATUS 4'h8
`define SC_REG_RDBK 4'hC

`endif

// ==== verilog/sc_pkg.sv ====
`default_nettype none

`include "sc_macros.svh"

package sc_pkg;

  // one slow-control word
  typedef logic [`SC_WORD_W-1:0] sc_word_t;
  // fifo fill count, one extra bit for full
  typedef logic [`SC_FIFO_AW:0] sc_level_t;
  typedef logic [3:0] sc_addr_t;
  // four Clk_5M phases per serial bit
  typedef logic [1:0] sc_phase_t;
  typedef logic [3:0] sc_bit_idx_t;

  // load sequencer states
  typedef enum logic [2:0] {
    st_idle, st_rst_hold, st_read, st_latency,
    st_load, st_shift, st_gap, st_end
  } sc_state_t;

endpackage

`default_nettype wire

// ==== verilog/sc_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sc_macros.svh"

module sc_apb_regs (
  input  wire                  Clk_5M,
  input  wire                  reset_n,
  input  wire sc_pkg::sc_addr_t paddr,
  input  wire                  psel,
  input  wire                  penable,
  input  wire                  pwrite,
  input  wire [31:0]           pwdata,
  input  wire                  fifo_full,
  input  wire sc_pkg::sc_level_t fifo_level,
  input  wire                  run_end,
  input  wire                  busy,
  input  wire sc_pkg::sc_word_t rdbk,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  output logic                 fifo_push,
  output sc_pkg::sc_word_t     fifo_wdata,
  output logic                 start_pulse
);
  import sc_pkg::*;

  logic        access;
  logic        wr_access;
  logic        rd_setup;
  logic        addr_ok;
  logic        done;
  logic [31:0] rd_mux;

  // no wait states
  assign pready = 1'b1;
  // access phase of a transfer
  assign access = psel & penable;
  assign wr_access = access & pwrite;
  // setup phase of a read, prdata is loaded here
  assign rd_setup = psel & ~penable & ~pwrite;

  assign addr_ok = (paddr == `SC_REG_CTRL) | (paddr == `SC_REG_DATA) |
                   (paddr == `SC_REG_STATUS) | (paddr == `SC_REG_RDBK);
  // bad offset, or data write into a full fifo
  assign pslverr = access & (~addr_ok | (pwrite & (paddr == `SC_REG_DATA) & fifo_full));

  // word dropped when full
  assign fifo_push = wr_access & (paddr == `SC_REG_DATA) & ~fifo_full;
  assign fifo_wdata = pwdata[$bits(sc_word_t)-1:0];
  // start ignored while a load runs
  assign start_pulse = wr_access & (paddr == `SC_REG_CTRL) & pwdata[0] & ~busy;

  // sticky done flag
  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      done <= 1'b0;
    end else if (run_end) begin
      done <= 1'b1;
    end else if (start_pulse | (wr_access & (paddr == `SC_REG_CTRL) & pwdata[1])) begin
      done <= 1'b0;
    end
  end

  // read data select
  always_comb begin
    rd_mux = '0;
    case (paddr)
      `SC_REG_STATUS: rd_mux = {{(24-$bits(sc_level_t)){1'b0}}, fifo_level,
                                5'b0, fifo_full, done, busy};
      `SC_REG_RDBK:   rd_mux = {{(32-$bits(sc_word_t)){1'b0}}, rdbk};
      default:        rd_mux = '0;
    endcase
  end

  // registered read data, zero again after the access
  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      prdata <= '0;
    end else if (rd_setup) begin
      prdata <= rd_mux;
    end else if (access) begin
      prdata <= '0;
    end
  end

  // one start pulse per accepted write
  a_start_single : assert property (@(posedge Clk_5M) disable iff (!reset_n)
    start_pulse |=> !start_pulse);

endmodule

`default_nettype wire

// ==== verilog/sc_param_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sc_macros.svh"

module sc_param_fifo (
  input  wire                   Clk_5M,
  input  wire                   reset_n,
  input  wire                   push,
  input  wire sc_pkg::sc_word_t wdata,
  input  wire                   pop,
  output sc_pkg::sc_word_t      rdata,
  output logic                  empty,
  output logic                  full,
  output sc_pkg::sc_level_t     level
);
  import sc_pkg::*;

  sc_word_t               mem [`SC_FIFO_DEPTH];
  logic [`SC_FIFO_AW-1:0] wr_ptr;
  logic [`SC_FIFO_AW-1:0] rd_ptr;

  assign empty = (level == '0);
  assign full = (level == sc_level_t'(`SC_FIFO_DEPTH));

  // pointers wrap at depth, level tracks fill
  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level <= '0;
    end else begin
      if (push & ~full)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop & ~empty)
        rd_ptr <= rd_ptr + 1'b1;
      level <= level + sc_level_t'(push & ~full) - sc_level_t'(pop & ~empty);
    end
  end

  // storage and registered read port
  always_ff @(posedge Clk_5M) begin
    if (push & ~full)
      mem[wr_ptr] <= wdata;
    if (pop & ~empty)
      rdata <= mem[rd_ptr];
  end

  // sequencer only pops a non-empty fifo
  a_no_pop_empty : assert property (@(posedge Clk_5M) disable iff (!reset_n)
    pop |-> !empty);
  // register block drops writes when full
  a_no_push_full : assert property (@(posedge Clk_5M) disable iff (!reset_n)
    push |-> !full);

endmodule

`default_nettype wire

// ==== verilog/sc_bit_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sc_bit_timer (
  input  wire           Clk_5M,
  input  wire           reset_n,
  input  wire           run,
  output sc_pkg::sc_phase_t phase,
  output logic          bit_tick,
  output logic          last_bit,
  output logic          sr_ck_raw
);
  import sc_pkg::*;

  sc_bit_idx_t bit_idx;

  ////////////////////////////////////////
  // phase and bit counters
  ////////////////////////////////////////

  // both held at zero between words
  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      phase <= '0;
      bit_idx <= '0;
    end else if (!run) begin
      phase <= '0;
      bit_idx <= '0;
    end else begin
      phase <= phase + 1'b1;
      if (bit_tick)
        bit_idx <= bit_idx + 1'b1;
    end
  end

  // last phase of a bit
  assign bit_tick = run & (phase == 2'd3);
  assign last_bit = bit_tick & (bit_idx == 4'd15);
  // quarter rate clock, high in phases 2 and 3
  assign sr_ck_raw = phase[1];

  // run only drops once the last bit of a word is done
  a_last_bit : assert property (@(posedge Clk_5M) disable iff (!reset_n)
    $fell(run) |-> $past(last_bit));

endmodule

`default_nettype wire

// ==== verilog/sc_load_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sc_macros.svh"

module sc_load_fsm (
  input  wire  Clk_5M,
  input  wire  reset_n,
  input  wire  start_pulse,
  input  wire  fifo_empty,
  input  wire  bit_tick,
  input  wire  last_bit,
  output logic fifo_pop,
  output logic timer_run,
  output logic load,
  output logic shift_en,
  output logic sr_ck_en,
  output logic sr_rstb,
  output logic busy,
  output logic run_end
);
  import sc_pkg::*;

  sc_state_t  state;
  sc_state_t  state_nxt;
  logic [2:0] hold_cnt;
  logic       hold_done;

  // last cycle of the register reset pulse
  assign hold_done = (hold_cnt == 3'(`SC_RSTB_CYCLES - 1));

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:     if (start_pulse) state_nxt = st_rst_hold;
      st_rst_hold: if (hold_done) state_nxt = st_read;
      // empty fifo ends the run
      st_read:     state_nxt = fifo_empty ? st_end : st_latency;
      // fifo read data arrives here
      st_latency:  state_nxt = st_load;
      st_load:     state_nxt = st_shift;
      // 16 bits of 4 phases each
      st_shift:    if (bit_tick & last_bit) state_nxt = st_gap;
      st_gap:      state_nxt = st_read;
      st_end:      state_nxt = st_idle;
      default:     state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
      hold_cnt <= '0;
    end else begin
      state <= state_nxt;
      // counts only during the hold
      hold_cnt <= (state == st_rst_hold) ? hold_cnt + 1'b1 : 3'd0;
    end
  end

  ////////////////////////////////////////
  // state decodes
  ////////////////////////////////////////
  assign fifo_pop = (state == st_read) & ~fifo_empty;
  assign load = (state == st_load);
  assign timer_run = (state == st_shift);
  assign shift_en = (state == st_shift);
  // serial clock off in the gap
  assign sr_ck_en = (state == st_shift);
  assign sr_rstb = (state != st_rst_hold);
  assign busy = (state != st_idle);
  assign run_end = (state == st_end);

  // a start only arrives between runs
  a_start_idle : assert property (@(posedge Clk_5M) disable iff (!reset_n)
    start_pulse |-> (state == st_idle));

endmodule

`default_nettype wire

// ==== verilog/sc_shift_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module sc_shift_out (
  input  wire                   Clk_5M,
  input  wire                   reset_n,
  input  wire                   load,
  input  wire sc_pkg::sc_word_t wdata,
  input  wire                   shift_en,
  input  wire                   bit_tick,
  input  wire                   sr_ck_raw,
  input  wire                   sr_ck_en,
  input  wire                   sr_out,
  output logic                  sr_ck,
  output logic                  sr_in,
  output sc_pkg::sc_word_t      rdbk
);
  import sc_pkg::*;

  sc_word_t shreg;
  logic     sr_ck_q;
  logic     ck_rise;

  // gated serial clock to the chip
  assign sr_ck = sr_ck_en & sr_ck_raw;
  // msb first, changes only at phase 0
  assign sr_in = shreg[$bits(sc_word_t)-1];
  assign ck_rise = sr_ck & ~sr_ck_q;

  // parallel load, shift left at end of each bit
  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      shreg <= '0;
    end else if (load) begin
      shreg <= wdata;
    end else if (shift_en & bit_tick) begin
      shreg <= shreg << 1;
    end
  end

  // chip output sampled on rising sr_ck
  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      sr_ck_q <= 1'b0;
      rdbk <= '0;
    end else begin
      sr_ck_q <= sr_ck;
      if (ck_rise)
        rdbk <= {rdbk[$bits(sc_word_t)-2:0], sr_out};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sc_config_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sc_config_top (
  input  wire                   Clk_5M,
  input  wire                   reset_n,
  input  wire sc_pkg::sc_addr_t paddr,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire [31:0]            pwdata,
  input  wire                   sr_out,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  sr_ck,
  output logic                  sr_rstb,
  output logic                  sr_in
);
  import sc_pkg::*;

  ////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////
  logic      fifo_push;
  logic      fifo_pop;
  logic      fifo_empty;
  logic      fifo_full;
  sc_word_t  fifo_wdata;
  sc_word_t  fifo_rdata;
  sc_level_t fifo_level;
  sc_word_t  rdbk;
  logic      start_pulse;
  logic      busy;
  logic      run_end;
  logic      timer_run;
  logic      load;
  logic      shift_en;
  logic      sr_ck_en;
  logic      bit_tick;
  logic      last_bit;
  logic      sr_ck_raw;

  sc_apb_regs regs_i (
    .Clk_5M, .reset_n, .paddr, .psel, .penable, .pwrite, .pwdata,
    .fifo_full, .fifo_level, .run_end, .busy, .rdbk,
    .prdata, .pready, .pslverr, .fifo_push, .fifo_wdata, .start_pulse
  );

  sc_param_fifo fifo_i (
    .Clk_5M, .reset_n, .push(fifo_push), .wdata(fifo_wdata), .pop(fifo_pop),
    .rdata(fifo_rdata), .empty(fifo_empty), .full(fifo_full), .level(fifo_level)
  );

  sc_load_fsm fsm_i (
    .Clk_5M, .reset_n, .start_pulse, .fifo_empty, .bit_tick, .last_bit,
    .fifo_pop, .timer_run, .load, .shift_en, .sr_ck_en, .sr_rstb, .busy, .run_end
  );

  // phase only drives sr_ck_raw inside the timer
  sc_bit_timer timer_i (
    .Clk_5M, .reset_n, .run(timer_run),
    .phase(), .bit_tick, .last_bit, .sr_ck_raw
  );

  sc_shift_out shift_i (
    .Clk_5M, .reset_n, .load, .wdata(fifo_rdata), .shift_en, .bit_tick,
    .sr_ck_raw, .sr_ck_en, .sr_out, .sr_ck, .sr_in, .rdbk
  );

endmodule

`default_nettype wire

// ==== tests/tb_sc_config.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sc_macros.svh"

module tb_sc_config;
  import sc_pkg::*;

  localparam int NUM_RUNS = 6;
  localparam int WORD_CYCLES = 68;

  logic        Clk_5M;
  logic        reset_n;
  sc_addr_t    paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        sr_ck;
  logic        sr_rstb;
  logic        sr_in;
  logic        sr_out = 1'b0;

  // chip shift register and what it saw
  logic [31:0] chip = '0;
  sc_word_t    rdbk_model = '0;
  logic        got_q[$];
  int          rstb_low_cnt = 0;

  integer      seed = 58287;
  int          run_words[NUM_RUNS];
  int          limit_cycles = 0;
  // words accepted by DATA writes, in order
  sc_word_t    exp_q[$];

  sc_config_top dut_i (
    .Clk_5M, .reset_n, .paddr, .psel, .penable, .pwrite, .pwdata, .sr_out,
    .prdata, .pready, .pslverr, .sr_ck, .sr_rstb, .sr_in
  );

  // 5 MHz
  initial begin
    Clk_5M = 1'b0;
    forever #100 Clk_5M = ~Clk_5M;
  end

  // bounded by the total word count
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge Clk_5M);
    $display("timeout, the load sequence did not finish within %0d cycles", limit_cycles);
    abort_run();
  end

  ////////////////////////////////////////
  // chip model
  ////////////////////////////////////////

  // cycles with the register reset held low
  always @(posedge Clk_5M) begin
    if (reset_n && !sr_rstb)
      rstb_low_cnt <= rstb_low_cnt + 1;
  end

  // samples sr_in on rising sr_ck, msb back out on sr_out
  always @(posedge sr_ck or negedge sr_rstb) begin
    if (!sr_rstb) begin
      chip = '0;
    end else begin
      got_q.push_back(sr_in);
      chip = {chip[30:0], sr_in};
      // bit the DUT captures one clock later
      rdbk_model = {rdbk_model[14:0], chip[31]};
    end
    #10;
    sr_out = chip[31];
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first mismatch");
  endtask

  task automatic check_word(input string name, input sc_word_t got, input sc_word_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_level(input string name, input sc_level_t got, input sc_level_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // APB access
  ////////////////////////////////////////

  // setup, access, then idle; pslverr taken mid access
  task automatic write_reg(input sc_addr_t addr, input logic [31:0] data, output logic err);
    @(posedge Clk_5M);
    #10;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge Clk_5M);
    #10;
    penable = 1'b1;
    @(negedge Clk_5M);
    check_flag("pready", pready, 1'b1);
    err = pslverr;
    @(posedge Clk_5M);
    #10;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  // prdata is registered at the end of setup
  task automatic read_reg(input sc_addr_t addr, output logic [31:0] data);
    @(posedge Clk_5M);
    #10;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge Clk_5M);
    #10;
    penable = 1'b1;
    @(negedge Clk_5M);
    check_flag("pready", pready, 1'b1);
    check_flag("pslverr", pslverr, 1'b0);
    data = prdata;
    @(posedge Clk_5M);
    #10;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic verify_status(input logic busy, input logic done, input logic full,
                               input sc_level_t level);
    logic [31:0] st;
    read_reg(`SC_REG_STATUS, st);
    check_flag("status busy", st[0], busy);
    check_flag("status done", st[1], done);
    check_flag("status full", st[2], full);
    check_level("status level", st[8 +: $bits(sc_level_t)], level);
  endtask

  // random words, upper pwdata bits are junk
  task automatic push_words(input int n);
    logic [31:0] d;
    logic        err;
    for (int i = 0; i < n; i++) begin
      d = $random(seed);
      write_reg(`SC_REG_DATA, d, err);
      check_flag("pslverr on data write", err, 1'b0);
      exp_q.push_back(sc_word_t'(d));
    end
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[1])
      read_reg(`SC_REG_STATUS, st);
  endtask

  ////////////////////////////////////////
  // one load run and its checks
  ////////////////////////////////////////
  task automatic run_load();
    int          base_bits;
    int          base_rstb;
    int          n;
    logic        err;
    logic [31:0] rd;
    sc_word_t    w;
    base_bits = got_q.size();
    base_rstb = rstb_low_cnt;
    n = exp_q.size();
    write_reg(`SC_REG_CTRL, 32'h1, err);
    check_flag("pslverr on start", err, 1'b0);
    // second start lands while busy
    write_reg(`SC_REG_CTRL, 32'h1, err);
    check_flag("pslverr on busy start", err, 1'b0);
    wait_done();
    verify_status(1'b0, 1'b1, 1'b0, '0);
    check_count("sr_ck rising edges", got_q.size() - base_bits, 16 * n);
    check_count("sr_rstb low cycles", rstb_low_cnt - base_rstb, `SC_RSTB_CYCLES);
    // sr_in seen at each edge, grouped msb first
    for (int i = 0; i < n; i++) begin
      w = '0;
      for (int b = 0; b < 16; b++)
        w = {w[14:0], got_q[base_bits + 16 * i + b]};
      check_word("sr_in word", w, exp_q[i]);
    end
    // upper half zero for one word, so reset hold cleared the chip
    check_word("chip low", chip[15:0], exp_q[n-1]);
    check_word("chip high", chip[31:16], (n > 1) ? exp_q[n-2] : '0);
    read_reg(`SC_REG_RDBK, rd);
    check_word("rdbk", rd[15:0], rdbk_model);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    int          total;
    logic        err;
    logic [31:0] d;
    reset_n = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    total = `SC_FIFO_DEPTH;
    foreach (run_words[i]) begin
      run_words[i] = 1 + int'($unsigned($random(seed)) % 8);
      total += run_words[i];
    end
    // apb overhead and polling per run
    limit_cycles = total * WORD_CYCLES + (NUM_RUNS + 1) * 300 + 200;
    repeat (16) @(posedge Clk_5M);
    #10;
    reset_n = 1'b1;

    // idle pins after reset
    check_flag("sr_ck", sr_ck, 1'b0);
    check_flag("sr_in", sr_in, 1'b0);
    check_flag("sr_rstb", sr_rstb, 1'b1);
    verify_status(1'b0, 1'b0, 1'b0, '0);

    foreach (run_words[i]) begin
      exp_q.delete();
      // done from the last run cleared by CTRL bit1
      write_reg(`SC_REG_CTRL, 32'h2, err);
      verify_status(1'b0, 1'b0, 1'b0, '0);
      push_words(run_words[i]);
      verify_status(1'b0, 1'b0, 1'b0, sc_level_t'(run_words[i]));
      run_load();
    end

    // fill to depth, one more is rejected
    exp_q.delete();
    write_reg(`SC_REG_CTRL, 32'h2, err);
    push_words(`SC_FIFO_DEPTH);
    d = $random(seed);
    write_reg(`SC_REG_DATA, d, err);
    check_flag("pslverr on full fifo", err, 1'b1);
    verify_status(1'b0, 1'b0, 1'b1, sc_level_t'(`SC_FIFO_DEPTH));
    run_load();
    write_reg(`SC_REG_CTRL, 32'h2, err);
    verify_status(1'b0, 1'b0, 1'b0, '0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
verilog/sc_pkg.sv
verilog/sc_apb_regs.sv
verilog/sc_param_fifo.sv
verilog/sc_bit_timer.sv
verilog/sc_load_fsm.sv
verilog/sc_shift_out.sv
verilog/sc_config_top.sv
tests/tb_sc_config.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_sc_config -f files.f \
  && ./obj_dir/Vtb_sc_config | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
